// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: fetch_axil_master.sv
module fetch_axil_master
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  input  logic        refill_valid_i,
  input  fetch_addr_u refill_addr_i,
  output logic        refill_ready_o,
  output logic        refill_done_o,
  output axil_r_t     refill_data_o,

  output logic        arvalid_o,
  output axil_ar_t    ar_o,
  input  logic        arready_i,

  input  logic        rvalid_i,
  input  axil_r_t     r_i,
  output logic        rready_o
);

  logic     arvalid_q;
  logic     rready_q;
  axil_ar_t ar_q;
  logic     refill_take;

  // One read at a time, from AR issue to R handshake
  assign refill_ready_o = !arvalid_q && !rready_q;
  assign refill_take    = refill_valid_i && refill_ready_o;

  assign arvalid_o = arvalid_q;
  assign ar_o      = ar_q;
  assign rready_o  = rready_q;

  assign refill_done_o = rready_q && rvalid_i;
  assign refill_data_o = r_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
    end
    else if (refill_take)
    begin
      arvalid_q <= 1'b1;
    end
    else if (arvalid_q && arready_i)
    begin
      arvalid_q <= 1'b0;
      rready_q  <= 1'b1;
    end
    else if (rready_q && rvalid_i)
    begin
      rready_q <= 1'b0;
    end
  end

  // Held unchanged until arready
  always_ff @(posedge clk)
  begin
    if (refill_take)
    begin
      ar_q.addr <= refill_addr_i.raw;
      ar_q.prot <= AXI_PROT_INST;
    end
  end

endmodule

// File: fetch_icache.sv
module fetch_icache
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  input  logic        flush_i,
  input  logic        redirect_valid_i,

  input  logic        req_valid_i,
  input  fetch_addr_u req_addr_i,
  output logic        req_ready_o,

  output logic        refill_valid_o,
  output fetch_addr_u refill_addr_o,
  input  logic        refill_ready_i,
  input  logic        refill_done_i,
  input  axil_r_t     refill_data_i,

  output logic        out_valid_o,
  output fetch_pkt_t  out_pkt_o,
  input  logic        out_ready_i
);

  logic [TAG_W-1:0]       tag_mem  [ICACHE_SETS];
  logic [DATA_W-1:0]      data_mem [ICACHE_SETS];
  logic [ICACHE_SETS-1:0] valid_q;

  logic [1:0]  miss_state_q;
  fetch_addr_u lk_addr_q;
  logic        squash_q;
  logic        nofill_q;

  logic        out_valid_q;
  fetch_pkt_t  out_pkt_q;

  logic lookup_hit;
  logic out_free;
  logic req_take;
  logic hit_take;
  logic miss_take;
  logic fill_done;
  logic fill_ok;

  assign lookup_hit = valid_q[req_addr_i.f.idx] &&
                      (tag_mem[req_addr_i.f.idx] == req_addr_i.f.tag);

  // Output slot free now or emptied this cycle, and no miss in flight
  assign out_free    = !out_valid_q || out_ready_i;
  assign req_ready_o = out_free && (miss_state_q == MISS_IDLE) &&
                       !redirect_valid_i && !flush_i;

  assign req_take  = req_valid_i && req_ready_o;
  assign hit_take  = req_take && lookup_hit;
  assign miss_take = req_take && !lookup_hit;

  assign fill_done = (miss_state_q == MISS_WAIT) && refill_done_i;
  assign fill_ok   = fill_done && (refill_data_i.resp == AXI_RESP_OKAY);

  assign refill_valid_o = (miss_state_q == MISS_REQ);
  assign refill_addr_o  = lk_addr_q;

  assign out_valid_o = out_valid_q;
  assign out_pkt_o   = out_pkt_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      miss_state_q <= MISS_IDLE;
      squash_q     <= 1'b0;
      nofill_q     <= 1'b0;
    end
    else
    begin
      case (miss_state_q)
        MISS_IDLE: if (miss_take) miss_state_q <= MISS_REQ;
        MISS_REQ:  if (refill_ready_i) miss_state_q <= MISS_WAIT;
        MISS_WAIT: if (refill_done_i) miss_state_q <= MISS_IDLE;
        default:   miss_state_q <= MISS_IDLE;
      endcase
      // A miss never starts in a redirect or flush cycle
      if (miss_take)
      begin
        squash_q <= 1'b0;
        nofill_q <= 1'b0;
      end
      else
      begin
        if (redirect_valid_i) squash_q <= 1'b1;
        if (flush_i) nofill_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (miss_take)
    begin
      lk_addr_q <= req_addr_i;
    end
    if (fill_ok)
    begin
      tag_mem[lk_addr_q.f.idx]  <= lk_addr_q.f.tag;
      data_mem[lk_addr_q.f.idx] <= refill_data_i.data;
    end
  end

  // Line goes valid only if no fence landed while the read was out
  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      valid_q <= '0;
    end
    else if (fill_ok && !nofill_q)
    begin
      valid_q[lk_addr_q.f.idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || redirect_valid_i)
    begin
      out_valid_q <= 1'b0;
    end
    else if (hit_take || (fill_done && !squash_q))
    begin
      out_valid_q <= 1'b1;
    end
    else if (out_ready_i)
    begin
      out_valid_q <= 1'b0;
    end
  end

  // Slot is known empty whenever a refill returns
  always_ff @(posedge clk)
  begin
    if (hit_take)
    begin
      out_pkt_q.pc   <= req_addr_i.raw;
      out_pkt_q.inst <= data_mem[req_addr_i.f.idx];
      out_pkt_q.err  <= 1'b0;
    end
    else if (fill_done)
    begin
      out_pkt_q.pc   <= lk_addr_q.raw;
      out_pkt_q.inst <= refill_data_i.data;
      out_pkt_q.err  <= (refill_data_i.resp != AXI_RESP_OKAY);
    end
  end

endmodule

// File: fetch_pc_gen.sv
module fetch_pc_gen
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,

  input  logic              req_ready_i,
  output logic              req_valid_o,
  output fetch_addr_u       req_addr_o
);

  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_d;
  logic              req_fire;

  // Fetch never idles, the cache throttles through ready
  assign req_valid_o    = 1'b1;
  assign req_fire       = req_valid_o && req_ready_i;
  assign req_addr_o.raw = pc_q;

  // Redirect wins over the sequential advance
  always_comb
  begin
    pc_d = pc_q;
    if (redirect_valid_i)
    begin
      pc_d = redirect_pc_i;
    end
    else if (req_fire)
    begin
      pc_d = pc_q + ADDR_W'(4);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC;
    end
    else
    begin
      pc_q <= pc_d;
    end
  end

endmodule

// File: fetch_pkg.sv
package fetch_pkg;

  // Bus and word widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  localparam logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000;

  // Direct-mapped cache geometry, one word per line
  localparam int IDX_W       = 8;
  localparam int TAG_W       = 22;
  localparam int OFF_W       = 2;
  localparam int ICACHE_SETS = 256;

  // AXI4-Lite encodings
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
  // Unprivileged, secure, instruction access
  localparam logic [2:0] AXI_PROT_INST = 3'b100;

  // Miss handling states of the cache
  localparam logic [1:0] MISS_IDLE = 2'd0;
  localparam logic [1:0] MISS_REQ  = 2'd1;
  localparam logic [1:0] MISS_WAIT = 2'd2;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic [OFF_W-1:0] off;
  } fetch_addr_fields_t;

  // Same word seen as a bus address or as cache fields
  typedef union packed {
    logic [ADDR_W-1:0]  raw;
    fetch_addr_fields_t f;
  } fetch_addr_u;

  // Packet handed to decode
  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] inst;
    logic              err;
  } fetch_pkt_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } axil_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axil_r_t;

endpackage

// File: fetch_tb.sv
module fetch_tb
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 9;
  localparam int WAIT_MAX = 400;

  typedef struct packed {
    logic [ADDR_W-1:0] target;
    logic [7:0]        count;
    logic              flush;
    logic              rand_ready;
    logic [7:0]        exp_ar;
  } row_t;

  logic              clk;
  logic              rst;
  logic              redirect_valid;
  logic [ADDR_W-1:0] redirect_pc;
  logic              flush;
  logic              out_valid;
  fetch_pkt_t        out_pkt;
  logic              out_ready;
  logic              arvalid;
  axil_ar_t          ar;
  logic              arready;
  logic              rvalid;
  axil_r_t           r;
  logic              rready;

  // Memory model state
  logic              ar_fire;
  logic              r_fire;
  logic [ADDR_W-1:0] ar_addr_s;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_pending;
  int unsigned       rd_delay;
  int unsigned       ar_count;

  fetch_pkt_t        pkt_q[$];
  row_t              rows [NUM_ROWS];
  int                errors;
  int                checks;

  fetch_unit_top DUT (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .flush_i          (flush),
    .out_valid_o      (out_valid),
    .out_pkt_o        (out_pkt),
    .out_ready_i      (out_ready),
    .arvalid_o        (arvalid),
    .ar_o             (ar),
    .arready_i        (arready),
    .rvalid_i         (rvalid),
    .r_i              (r),
    .rready_o         (rready)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Handshakes and packets sampled on the rising edge
  always @(posedge clk)
  begin
    ar_fire <= !rst && arvalid && arready;
    r_fire  <= !rst && rvalid && rready;
    if (!rst && arvalid && arready)
    begin
      ar_count  <= ar_count + 1;
      ar_addr_s <= ar.addr;
      checks++;
      // AxPROT[2] marks an instruction fetch
      assert (ar.prot[2] == 1'b1)
      else
      begin
        $display("Mismatch at %0t: AR prot %b, expected instruction access",
                 $time, ar.prot);
        errors++;
      end
    end
    if (!rst && out_valid && out_ready)
    begin
      pkt_q.push_back(out_pkt);
    end
  end

  // AXI4-Lite memory, one read at a time
  always @(negedge clk)
  begin
    if (rst)
    begin
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      rd_pending <= 1'b0;
    end
    else
    begin
      if (ar_fire)
      begin
        rd_addr    = ar_addr_s;
        rd_delay   = $urandom_range(0, 5);
        rd_pending = 1'b1;
      end
      if (r_fire)
      begin
        rvalid = 1'b0;
      end
      if (rd_pending && !rvalid)
      begin
        if (rd_delay == 0)
        begin
          rvalid     = 1'b1;
          r.data     = rd_addr ^ 32'h5a5a_5a5a;
          r.resp     = (rd_addr >= 32'h9000_0000) ? 2'b10 : AXI_RESP_OKAY;
          rd_pending = 1'b0;
        end
        else
        begin
          rd_delay = rd_delay - 1;
        end
      end
      arready = arvalid && !rd_pending && !rvalid;
    end
  end

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s at %0t", what, $time);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic check_packet(input int row, input fetch_pkt_t pkt,
                              input logic [ADDR_W-1:0] exp_pc);
    logic [DATA_W-1:0] exp_inst;
    logic              exp_err;
    exp_inst = exp_pc ^ 32'h5a5a_5a5a;
    exp_err  = (exp_pc >= 32'h9000_0000);
    checks   = checks + 3;
    assert (pkt.pc == exp_pc)
    else
    begin
      $display("Mismatch at %0t: row %0d pc %h, expected %h", $time, row, pkt.pc, exp_pc);
      errors++;
    end
    assert (pkt.inst == exp_inst)
    else
    begin
      $display("Mismatch at %0t: row %0d inst %h at pc %h, expected %h",
               $time, row, pkt.inst, exp_pc, exp_inst);
      errors++;
    end
    assert (pkt.err == exp_err)
    else
    begin
      $display("Mismatch at %0t: row %0d err %b at pc %h, expected %b",
               $time, row, pkt.err, exp_pc, exp_err);
      errors++;
    end
  endtask

  task automatic run_row(input int idx);
    row_t              row;
    int                got;
    int                waited;
    int unsigned       ar_start;
    int unsigned       ar_delta;
    int                err_start;
    logic [ADDR_W-1:0] exp_pc;
    fetch_pkt_t        pkt;
    row       = rows[idx];
    err_start = errors;
    // The first row runs straight out of reset
    if (idx != 0)
    begin
      flush          = row.flush;
      redirect_valid = 1'b1;
      redirect_pc    = row.target;
      out_ready      = 1'b0;
      @(negedge clk);
      flush          = 1'b0;
      redirect_valid = 1'b0;
    end
    // A read squashed by the redirect still runs to its R handshake
    waited = 0;
    while (arvalid || rready)
    begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_MAX)
      begin
        abort_on_timeout("the squashed read to complete");
      end
    end
    pkt_q.delete();
    ar_start = ar_count;
    exp_pc   = row.target;
    got      = 0;
    waited   = 0;
    while (got < row.count)
    begin
      while (pkt_q.size() > 0 && got < row.count)
      begin
        pkt = pkt_q.pop_front();
        check_packet(idx, pkt, exp_pc);
        exp_pc = exp_pc + 4;
        got++;
        waited = 0;
      end
      if (got < row.count)
      begin
        out_ready = row.rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
        @(negedge clk);
        waited++;
        if (waited > WAIT_MAX)
        begin
          abort_on_timeout("a fetch packet");
        end
      end
    end
    out_ready = 1'b0;
    ar_delta  = ar_count - ar_start;
    checks++;
    assert (ar_delta == row.exp_ar)
    else
    begin
      $display("Mismatch at %0t: row %0d saw %0d AR transfers, expected %0d",
               $time, idx, ar_delta, row.exp_ar);
      errors++;
    end
    $display("row %0d: target %h, %0d packets, %0d AR, %s", idx, row.target,
             got, ar_delta, (errors == err_start) ? "ok" : "errors");
  endtask

  initial
  begin
    void'($urandom(32'h1b22afa4));
    errors         = 0;
    checks         = 0;
    ar_count       = 0;
    rst            = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    flush          = 1'b0;
    out_ready      = 1'b0;
    arready        = 1'b0;
    rvalid         = 1'b0;
    r              = '0;
    rd_pending     = 1'b0;
    rd_delay       = 0;
    rd_addr        = '0;

    // target, packets, flush, random ready, expected AR
    rows[0] = '{32'h8000_0000, 8'd16, 1'b0, 1'b0, 8'd16};
    rows[1] = '{32'h8000_0000, 8'd16, 1'b0, 1'b1, 8'd0};
    // Last word came in through a squashed read
    rows[2] = '{32'h8000_0020, 8'd9,  1'b0, 1'b1, 8'd0};
    rows[3] = '{32'h8000_0000, 8'd8,  1'b1, 1'b0, 8'd8};
    // Same index, 1 KiB away
    rows[4] = '{32'h8000_0400, 8'd8,  1'b0, 1'b0, 8'd8};
    rows[5] = '{32'h8000_0000, 8'd8,  1'b0, 1'b1, 8'd8};
    rows[6] = '{32'h9000_0000, 8'd6,  1'b0, 1'b0, 8'd6};
    rows[7] = '{32'h9000_0000, 8'd6,  1'b0, 1'b1, 8'd6};
    // Errored reads at the same index must not have evicted these lines
    rows[8] = '{32'h8000_0010, 8'd4,  1'b0, 1'b0, 8'd0};

    repeat (3) @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      run_row(i);
    end

    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: fetch_tb_properties.sv
module fetch_tb_properties
  import fetch_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     arvalid_o,
  input axil_ar_t ar_o,
  input logic     arready_i,
  input logic     rvalid_i,
  input logic     rready_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Set by the AR handshake, cleared by the R handshake
  logic rd_outstanding_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_outstanding_q <= 1'b0;
    end
    else if (arvalid_o && arready_i)
    begin
      rd_outstanding_q <= 1'b1;
    end
    else if (rvalid_i && rready_o)
    begin
      rd_outstanding_q <= 1'b0;
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
    else $error("arvalid dropped or AR address changed before arready");

  a_rready_idle: assert property (@(posedge clk) disable iff (rst)
    !rd_outstanding_q |-> !rready_o)
    else $error("rready high with no read outstanding");

  a_reset_state: assert property (@(posedge clk)
    rst |=> !arvalid_o && !rready_o)
    else $error("arvalid or rready not low after reset");

endmodule

bind fetch_axil_master fetch_tb_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .arvalid_o (arvalid_o),
  .ar_o      (ar_o),
  .arready_i (arready_i),
  .rvalid_i  (rvalid_i),
  .rready_o  (rready_o)
);

// File: fetch_unit_top.sv
module fetch_unit_top
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              flush_i,

  output logic              out_valid_o,
  output fetch_pkt_t        out_pkt_o,
  input  logic              out_ready_i,

  output logic              arvalid_o,
  output axil_ar_t          ar_o,
  input  logic              arready_i,
  input  logic              rvalid_i,
  input  axil_r_t           r_i,
  output logic              rready_o
);

  // PC generator to cache
  logic        req_valid;
  logic        req_ready;
  fetch_addr_u req_addr;

  // Cache to bus master
  logic        refill_valid;
  logic        refill_ready;
  fetch_addr_u refill_addr;
  logic        refill_done;
  axil_r_t     refill_data;

  fetch_pc_gen u_pc_gen (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .req_ready_i      (req_ready),
    .req_valid_o      (req_valid),
    .req_addr_o       (req_addr)
  );

  fetch_icache u_icache (
    .clk              (clk),
    .rst              (rst),
    .flush_i          (flush_i),
    .redirect_valid_i (redirect_valid_i),
    .req_valid_i      (req_valid),
    .req_addr_i       (req_addr),
    .req_ready_o      (req_ready),
    .refill_valid_o   (refill_valid),
    .refill_addr_o    (refill_addr),
    .refill_ready_i   (refill_ready),
    .refill_done_i    (refill_done),
    .refill_data_i    (refill_data),
    .out_valid_o      (out_valid_o),
    .out_pkt_o        (out_pkt_o),
    .out_ready_i      (out_ready_i)
  );

  fetch_axil_master u_axil_master (
    .clk            (clk),
    .rst            (rst),
    .refill_valid_i (refill_valid),
    .refill_addr_i  (refill_addr),
    .refill_ready_o (refill_ready),
    .refill_done_o  (refill_done),
    .refill_data_o  (refill_data),
    .arvalid_o      (arvalid_o),
    .ar_o           (ar_o),
    .arready_i      (arready_i),
    .rvalid_i       (rvalid_i),
    .r_i            (r_i),
    .rready_o       (rready_o)
  );

endmodule

// File: vlog.f
fetch_pkg.sv
fetch_pc_gen.sv
fetch_icache.sv
fetch_axil_master.sv
fetch_unit_top.sv
fetch_tb_properties.sv
fetch_tb.sv
